/* all.f */
+incdir+test
src/rvCorePkg.sv
src/fetchUnit.sv
src/controlUnit.sv
src/regFile.sv
src/aluCompare.sv
src/dataMemory.sv
src/rvCore.sv
test/rvCoreTb.sv

/* src/aluCompare.sv */
// immediates, ALU and branch compare, purely combinational; shifts use the low 5 bits only
`timescale 1ns/10ps

module aluCompare (
    input  rvCorePkg::instS            inst,
    input  logic [rvCorePkg::xLen-1:0] pc,
    input  logic [rvCorePkg::xLen-1:0] rs1Data,
    input  logic [rvCorePkg::xLen-1:0] rs2Data,
    input  rvCorePkg::aluOpE           aluOp,
    input  logic                       aluSrcImm,
    output logic [rvCorePkg::xLen-1:0] aluResult,
    output logic [rvCorePkg::xLen-1:0] storeData,
    output logic [rvCorePkg::xLen-1:0] branchTarget,
    output rvCorePkg::cmpS             cmp
);

    logic [rvCorePkg::xLen-1:0] immI;
    logic [rvCorePkg::xLen-1:0] immS;
    logic [rvCorePkg::xLen-1:0] immB;
    logic [rvCorePkg::xLen-1:0] opA;
    logic [rvCorePkg::xLen-1:0] opB;
    logic [4:0]                 shamt;

    assign immI = {{20{inst.funct7[6]}}, inst.funct7, inst.rs2};
    assign immS = {{20{inst.funct7[6]}}, inst.funct7, inst.rd};
    // B layout scatters imm[11] into rd[0]
    assign immB = {{20{inst.funct7[6]}}, inst.rd[0], inst.funct7[5:0], inst.rd[4:1], 1'b0};

    assign opA   = rs1Data;
    assign opB   = !aluSrcImm ? rs2Data :
                   (inst.opcode == rvCorePkg::opStore) ? immS : immI;
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            rvCorePkg::aluSub:  aluResult = opA - opB;
            rvCorePkg::aluAnd:  aluResult = opA & opB;
            rvCorePkg::aluOr:   aluResult = opA | opB;
            rvCorePkg::aluXor:  aluResult = opA ^ opB;
            rvCorePkg::aluSll:  aluResult = opA << shamt;
            rvCorePkg::aluSrl:  aluResult = opA >> shamt;
            rvCorePkg::aluSra:  aluResult = $signed(opA) >>> shamt;
            rvCorePkg::aluSlt:  aluResult = {31'd0, $signed(opA) < $signed(opB)};
            rvCorePkg::aluSltu: aluResult = {31'd0, opA < opB};
            default:            aluResult = opA + opB;   // add, also address calc
        endcase
    end

    // flags always compare the two registers
    assign cmp.eq  = rs1Data == rs2Data;
    assign cmp.lt  = $signed(rs1Data) < $signed(rs2Data);
    assign cmp.ltu = rs1Data < rs2Data;

    assign storeData    = rs2Data;
    assign branchTarget = pc + immB;

endmodule

/* src/controlUnit.sv */
// fetch/execute sequencer with decode; run is looked at only in fetch, unknown opcodes do nothing
`timescale 1ns/10ps

module controlUnit (
    input  logic                clk,
    input  logic                rstN,
    input  logic                run,
    input  rvCorePkg::instS     inst,
    input  rvCorePkg::cmpS      cmp,
    output rvCorePkg::cpuStateE state,
    output rvCorePkg::ctrlS     ctrl
);

    // funct7[5] only matters for sub and sra; no subi exists
    function automatic rvCorePkg::aluOpE aluDecode(input rvCorePkg::instS i, input logic isReg);
        rvCorePkg::aluOpE op;
        case (i.funct3)
            3'd0: op = (isReg && i.funct7[5]) ? rvCorePkg::aluSub : rvCorePkg::aluAdd;
            3'd1: op = rvCorePkg::aluSll;
            3'd2: op = rvCorePkg::aluSlt;
            3'd3: op = rvCorePkg::aluSltu;
            3'd4: op = rvCorePkg::aluXor;
            3'd5: op = i.funct7[5] ? rvCorePkg::aluSra : rvCorePkg::aluSrl;
            3'd6: op = rvCorePkg::aluOr;
            default: op = rvCorePkg::aluAnd;
        endcase
        return op;
    endfunction

    function automatic logic branchDecide(input logic [2:0] f3, input rvCorePkg::cmpS c);
        case (f3)
            3'd0: return c.eq;      // beq
            3'd1: return !c.eq;     // bne
            3'd4: return c.lt;      // blt
            3'd5: return !c.lt;     // bge
            3'd6: return c.ltu;     // bltu
            3'd7: return !c.ltu;    // bgeu
            default: return 1'b0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= rvCorePkg::stFetch;
        end else if (state == rvCorePkg::stExecute) begin
            state <= rvCorePkg::stFetch;   // execute always finishes
        end else if (run) begin
            state <= rvCorePkg::stExecute;
        end
    end

    always_comb begin
        ctrl = '0;
        if (state == rvCorePkg::stExecute) begin
            case (inst.opcode)
                rvCorePkg::opR: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = aluDecode(inst, 1'b1);
                end
                rvCorePkg::opImm: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.aluOp     = aluDecode(inst, 1'b0);
                end
                rvCorePkg::opLoad: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.memToReg  = 1'b1;
                end
                rvCorePkg::opStore: begin
                    ctrl.memWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
                rvCorePkg::opBranch: begin
                    ctrl.branchTaken = branchDecide(inst.funct3, cmp);
                end
                default: ;
            endcase
        end
    end

    noDualWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.regWrite && ctrl.memWrite))
        else $error("register and memory write in the same cycle");

    idleInFetch: assert property (@(posedge clk) disable iff (!rstN)
        state == rvCorePkg::stFetch |-> !(ctrl.regWrite || ctrl.memWrite || ctrl.branchTaken))
        else $error("write or branch issued during fetch");

endmodule

/* src/dataMemory.sv */
// word data memory cleared at reset, indexed by address bits 7:2; no byte or halfword access
`timescale 1ns/10ps

module dataMemory (
    input  logic                       clk,
    input  logic                       rstN,
    input  rvCorePkg::cpuStateE        state,
    input  rvCorePkg::ctrlS            ctrl,
    input  logic [rvCorePkg::xLen-1:0] aluResult,
    input  logic [rvCorePkg::xLen-1:0] storeData,
    output logic [rvCorePkg::xLen-1:0] wbData,
    output logic                       storeValid,
    output rvCorePkg::storeS           store
);

    logic [rvCorePkg::xLen-1:0]      mem [rvCorePkg::dmemDepth];
    logic [rvCorePkg::dmemAddrW-1:0] wordIdx;
    logic                            doWrite;

    assign wordIdx = aluResult[rvCorePkg::dmemAddrW+1:2];
    assign doWrite = (state == rvCorePkg::stExecute) && ctrl.memWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < rvCorePkg::dmemDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (doWrite) begin
            mem[wordIdx] <= storeData;
        end
    end

    // store report, address shown word aligned
    assign storeValid = doWrite;
    assign store.addr = {aluResult[rvCorePkg::xLen-1:2], 2'b00};
    assign store.data = storeData;

    assign wbData = ctrl.memToReg ? mem[wordIdx] : aluResult;

    storeOnlyInExecute: assert property (@(posedge clk) disable iff (!rstN)
        storeValid |=> !storeValid)
        else $error("store strobe held longer than one cycle");

endmodule

/* src/fetchUnit.sv */
// pc and instruction memory; progAddr is a word index; load only while the core is paused
`timescale 1ns/10ps

module fetchUnit (
    input  logic                            clk,
    input  logic                            rstN,
    input  rvCorePkg::cpuStateE             state,
    input  logic                            run,
    input  logic                            branchTaken,
    input  logic [rvCorePkg::xLen-1:0]      branchTarget,
    input  logic                            progWe,
    input  logic [rvCorePkg::imemAddrW-1:0] progAddr,
    input  logic [rvCorePkg::xLen-1:0]      progData,
    output logic [rvCorePkg::xLen-1:0]      pc,
    output rvCorePkg::instS                 inst
);

    logic [rvCorePkg::xLen-1:0] imem [rvCorePkg::imemDepth];
    logic [rvCorePkg::xLen-1:0] nextPc;

    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr] <= progData;
        end
    end

    // instruction register loads on the fetch edge
    always_ff @(posedge clk) begin
        if (state == rvCorePkg::stFetch && run) begin
            inst <= rvCorePkg::instS'(imem[pc[rvCorePkg::imemAddrW+1:2]]);
        end
    end

    assign nextPc = branchTaken ? branchTarget : pc + 32'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (state == rvCorePkg::stExecute) begin
            pc <= nextPc;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc lost word alignment: %h", pc);

endmodule

/* src/regFile.sv */
// 31 registers cleared at reset, x0 reads zero; same-edge write is not forwarded to the reads
`timescale 1ns/10ps

module regFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [4:0]                 rs1,
    input  logic [4:0]                 rs2,
    input  logic [4:0]                 rd,
    input  logic                       we,
    input  logic [rvCorePkg::xLen-1:0] wdata,
    output logic [rvCorePkg::xLen-1:0] rs1Data,
    output logic [rvCorePkg::xLen-1:0] rs2Data
);

    logic [rvCorePkg::xLen-1:0] regs [31:1];   // no storage for x0

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    always_comb begin
        if (rs1 == 5'd0) begin
            rs1Data = '0;
        end else begin
            rs1Data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == 5'd0) begin
            rs2Data = '0;
        end else begin
            rs2Data = regs[rs2];
        end
    end

endmodule

/* src/rvCore.sv */
// core top; one instruction per two cycles while run is high, strobes are single-cycle pulses
`timescale 1ns/10ps

module rvCore (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            run,
    input  logic                            progWe,
    input  logic [rvCorePkg::imemAddrW-1:0] progAddr,
    input  logic [rvCorePkg::xLen-1:0]      progData,
    output logic                            retireValid,
    output rvCorePkg::retireS               retire,
    output logic                            storeValid,
    output rvCorePkg::storeS                store
);

    rvCorePkg::cpuStateE        state;
    rvCorePkg::ctrlS            ctrl;
    rvCorePkg::instS            inst;
    rvCorePkg::cmpS             cmp;
    logic [rvCorePkg::xLen-1:0] pc;
    logic [rvCorePkg::xLen-1:0] rs1Data;
    logic [rvCorePkg::xLen-1:0] rs2Data;
    logic [rvCorePkg::xLen-1:0] aluResult;
    logic [rvCorePkg::xLen-1:0] storeData;
    logic [rvCorePkg::xLen-1:0] branchTarget;
    logic [rvCorePkg::xLen-1:0] wbData;

    fetchUnit uFetch (
        .clk         (clk),
        .rstN        (rstN),
        .state       (state),
        .run         (run),
        .branchTaken (ctrl.branchTaken),
        .branchTarget(branchTarget),
        .progWe      (progWe),
        .progAddr    (progAddr),
        .progData    (progData),
        .pc          (pc),
        .inst        (inst)
    );

    controlUnit uCtrl (
        .clk  (clk),
        .rstN (rstN),
        .run  (run),
        .inst (inst),
        .cmp  (cmp),
        .state(state),
        .ctrl (ctrl)
    );

    regFile uRegs (
        .clk    (clk),
        .rstN   (rstN),
        .rs1    (inst.rs1),
        .rs2    (inst.rs2),
        .rd     (inst.rd),
        .we     (ctrl.regWrite),   // already gated to execute
        .wdata  (wbData),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    aluCompare uAlu (
        .inst        (inst),
        .pc          (pc),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .aluOp       (ctrl.aluOp),
        .aluSrcImm   (ctrl.aluSrcImm),
        .aluResult   (aluResult),
        .storeData   (storeData),
        .branchTarget(branchTarget),
        .cmp         (cmp)
    );

    dataMemory uDmem (
        .clk       (clk),
        .rstN      (rstN),
        .state     (state),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .storeData (storeData),
        .wbData    (wbData),
        .storeValid(storeValid),
        .store     (store)
    );

    // every execute cycle retires, unknown opcodes included
    assign retireValid     = state == rvCorePkg::stExecute;
    assign retire.pc       = pc;
    assign retire.rd       = inst.rd;
    assign retire.wdata    = wbData;
    assign retire.regWrite = ctrl.regWrite;

endmodule

/* src/rvCorePkg.sv */
// shared types for the RV32I subset core; word-only memories, no traps, opcode field kept raw
package rvCorePkg;

    localparam int xLen      = 32;
    localparam int imemDepth = 64;
    localparam int imemAddrW = 6;
    localparam int dmemDepth = 64;
    localparam int dmemAddrW = 6;

    typedef enum logic {
        stFetch,
        stExecute
    } cpuStateE;

    // major opcodes handled by the decoder, anything else is a no-op
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd,     // must stay zero, idle control word
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt,
        aluSltu
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  memWrite;
        logic  aluSrcImm;
        logic  memToReg;
        logic  branchTaken;
        aluOpE aluOp;
    } ctrlS;

    typedef struct packed {
        logic eq;
        logic lt;   // signed
        logic ltu;
    } cmpS;

    // field order follows the RV32 encoding, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instS;

    typedef struct packed {
        logic [xLen-1:0] pc;
        logic [4:0]      rd;
        logic [xLen-1:0] wdata;
        logic            regWrite;
    } retireS;

    typedef struct packed {
        logic [xLen-1:0] addr;
        logic [xLen-1:0] data;
    } storeS;

endpackage

/* test/isaModel.svh */
// included in the testbench module; memory ops use x0 as base, branches only jump forward
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int rndSeed   = 32'h761773f3;
localparam int progLen   = 52;    // words, rest of imem stays zero
localparam int waitLimit = 200;   // cycles without a retire

integer            seed = rndSeed;
logic [31:0]       prog [64];
rvCorePkg::retireS expRetire [$];
rvCorePkg::storeS  expStore [$];

function automatic int pick(input int n);
    return $unsigned($random(seed)) % n;
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

task automatic genProgram();
    int          i;
    int          kind;
    int          hop;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    for (i = 0; i < 64; i++) begin
        prog[i] = '0;
    end
    prog[0] = encI(12'hfff, 5'd0, 3'd0, 5'd1, 7'b0010011);   // x1 = -1
    prog[1] = encI(12'h001, 5'd0, 3'd0, 5'd2, 7'b0010011);
    prog[2] = encI(12'h01f, 5'd2, 3'd1, 5'd3, 7'b0010011);   // x3 = most negative
    prog[3] = encI(12'h001, 5'd1, 3'd5, 5'd4, 7'b0010011);   // x4 = most positive
    for (i = 4; i < progLen - 2; i++) begin
        kind = pick(10);
        hop  = pick(12);
        rd   = (hop == 0) ? 5'd0 : 5'(hop + 4);   // x1..x4 are never overwritten
        rs1  = 5'(pick(16));
        rs2  = 5'(pick(16));
        f3   = 3'(pick(8));
        imm  = 12'(pick(4096));
        if (kind < 3) begin
            imm[11:5] = ((f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1) ? 7'h20 : 7'h00;
            prog[i] = {imm[11:5], rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind < 5) begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm[11:5] = (f3 == 3'd5 && pick(2) == 1) ? 7'h20 : 7'h00;
            end
            prog[i] = encI(imm, rs1, f3, rd, 7'b0010011);
        end else if (kind == 5) begin
            imm = 12'(4 * pick(16));
            prog[i] = {imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], 7'b0100011};   // sw
        end else if (kind == 6) begin
            prog[i] = encI(12'(4 * pick(16)), 5'd0, 3'd2, rd, 7'b0000011);  // lw
        end else begin
            if (f3 == 3'd2 || f3 == 3'd3) begin
                f3 = f3 + 3'd4;
            end
            hop = 2 + pick(4);
            if (i + hop > progLen - 2) begin
                hop = progLen - 2 - i;   // never skip the x0 tail
            end
            prog[i] = encB(13'(4 * hop), rs2, rs1, f3);
        end
    end
    prog[progLen-2] = encI(12'h7ff, 5'd0, 3'd0, 5'd0, 7'b0010011);  // write to x0
    prog[progLen-1] = {7'h00, 5'd0, 5'd0, 3'd0, 5'd6, 7'b0110011};  // x6 = x0 + x0
endtask

function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// walks the image once from pc 0 up to the end of imem
task automatic runModel();
    logic [31:0]       x [32];
    logic [31:0]       dm [64];
    logic [31:0]       pc;
    logic [31:0]       w;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       immI;
    logic [31:0]       immS;
    logic [31:0]       immB;
    logic              take;
    rvCorePkg::retireS r;
    rvCorePkg::storeS  s;
    for (int i = 0; i < 64; i++) begin
        dm[i] = '0;
        x[i % 32] = '0;
    end
    pc = '0;
    while (pc < 32'd256) begin
        w    = prog[pc[7:2]];
        a    = x[w[19:15]];
        b    = x[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        r    = '{pc: pc, rd: w[11:7], wdata: '0, regWrite: 1'b0};
        take = 1'b0;
        case (w[6:0])
            7'b0110011: r.wdata = aluModel(w[14:12], w[30], a, b);
            7'b0010011: r.wdata = aluModel(w[14:12], w[30] && w[14:12] == 3'd5, a, immI);
            7'b0000011: r.wdata = dm[(a + immI) >> 2 & 32'd63];
            7'b0100011: begin
                s.addr = (a + immS) & ~32'd3;
                s.data = b;
                dm[s.addr[7:2]] = b;
                expStore.push_back(s);
            end
            7'b1100011: begin
                case (w[14:12])
                    3'd0: take = a == b;
                    3'd1: take = a != b;
                    3'd4: take = $signed(a) < $signed(b);
                    3'd5: take = $signed(a) >= $signed(b);
                    3'd6: take = a < b;
                    3'd7: take = a >= b;
                    default: take = 1'b0;
                endcase
            end
            default: ;
        endcase
        r.regWrite = w[6:0] inside {7'b0110011, 7'b0010011, 7'b0000011};
        if (r.regWrite && r.rd != 5'd0) begin
            x[r.rd] = r.wdata;
        end
        expRetire.push_back(r);
        pc = take ? pc + immB : pc + 32'd4;
    end
endtask

`endif

/* test/rvCoreTb.sv */
// drives rvCore with one random program; outputs are sampled and inputs driven on falling edges
`timescale 1ns/10ps

module rvCoreTb;

    logic                            clk;
    logic                            rstN;
    logic                            run;
    logic                            progWe;
    logic [rvCorePkg::imemAddrW-1:0] progAddr;
    logic [rvCorePkg::xLen-1:0]      progData;
    logic                            retireValid;
    rvCorePkg::retireS               retire;
    logic                            storeValid;
    rvCorePkg::storeS                store;

    int    checks [1:6];
    int    errs [1:6];
    string names [1:6] = '{"reset and start", "alu results", "memory", "branches",
                           "pausing", "unknown opcodes"};
    int    cycle;
    int    lastRetire;   // -1 until the first retire
    logic  runDipped;    // run went low since the last retire

    `include "isaModel.svh"

    rvCore dut (
        .clk        (clk),
        .rstN       (rstN),
        .run        (run),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .retireValid(retireValid),
        .retire     (retire),
        .storeValid (storeValid),
        .store      (store)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkEq(input int t, input string name, input logic [31:0] expV,
                           input logic [31:0] gotV);
        checks[t]++;
        if (gotV !== expV) begin
            errs[t]++;
            $display("ERR %s expected %h got %h at cycle %0d", name, expV, gotV, cycle);
        end
    endtask

    task automatic reportFault(input int t, input string msg);
        errs[t]++;
        $display("cycle %0d: %s", cycle, msg);
    endtask

    task automatic checkQuiet();
        checks[1]++;
        if (retireValid !== 1'b0 || storeValid !== 1'b0) begin
            reportFault(1, "strobe seen during reset or program load");
        end
    endtask

    function automatic int testFor(input logic [31:0] w);
        case (w[6:0])
            7'b0110011, 7'b0010011: return 2;
            7'b0000011, 7'b0100011: return 3;
            7'b1100011: return 4;
            default: return 6;
        endcase
    endfunction

    task automatic checkCycle();
        rvCorePkg::retireS e;
        rvCorePkg::storeS  s;
        logic [31:0]       w;
        int                t;
        checks[5]++;
        if (run === 1'b0 && retireValid === 1'b1) begin
            reportFault(5, "instruction retired although run was low");
        end
        if (retireValid !== 1'b1) begin
            checks[3]++;
            if (storeValid !== 1'b0) begin
                reportFault(3, "store strobe without a retire");
            end
            return;
        end
        if (expRetire.size() == 0) begin
            reportFault(6, "retire after the expected sequence ended");
            return;
        end
        e = expRetire.pop_front();
        w = prog[e.pc[7:2]];
        t = testFor(w);
        if (lastRetire < 0) begin
            checkEq(1, "retire.pc", 32'd0, retire.pc);
        end else if (!runDipped) begin
            checkEq(1, "retire spacing", 32'd2, 32'(cycle - lastRetire));
        end
        lastRetire = cycle;
        runDipped  = 1'b0;
        checkEq(t, "retire.pc", e.pc, retire.pc);
        checkEq(t, "retire.regWrite", 32'(e.regWrite), 32'(retire.regWrite));
        if (e.regWrite) begin
            checkEq(t, "retire.rd", 32'(e.rd), 32'(retire.rd));
            checkEq(t, "retire.wdata", e.wdata, retire.wdata);
        end
        if (w[6:0] != 7'b0100011) begin
            checks[3]++;
            if (storeValid !== 1'b0) begin
                reportFault(3, "store strobe on an instruction that is not a store");
            end
        end else if (storeValid !== 1'b1 || expStore.size() == 0) begin
            reportFault(3, "store retired without a matching store strobe");
        end else begin
            s = expStore.pop_front();
            checkEq(3, "store.addr", s.addr, store.addr);
            checkEq(3, "store.data", s.data, store.data);
        end
    endtask

    initial begin
        int k;
        int idle;
        int pauseLeft;
        int total;
        int totalChecks;
        rstN       = 1'b0;
        run        = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        cycle      = 0;
        lastRetire = -1;
        runDipped  = 1'b0;
        idle       = 0;
        pauseLeft  = 0;
        for (k = 1; k <= 6; k++) begin
            checks[k] = 0;
            errs[k]   = 0;
        end
        genProgram();
        runModel();

        for (k = 0; k < 8; k++) begin
            @(negedge clk);
            checkQuiet();
        end
        rstN = 1'b1;
        for (k = 0; k < rvCorePkg::imemDepth; k++) begin
            @(negedge clk);
            checkQuiet();
            progWe   = 1'b1;
            progAddr = k[rvCorePkg::imemAddrW-1:0];
            progData = prog[k];
        end
        @(negedge clk);
        checkQuiet();
        progWe = 1'b0;
        run    = 1'b1;

        // run until the model's retire list is used up, with random pauses
        while (expRetire.size() > 0 && idle <= waitLimit) begin
            @(negedge clk);
            cycle++;
            checkCycle();
            idle = (retireValid === 1'b1) ? 0 : idle + 1;
            if (idle > waitLimit) begin
                reportFault(5, "timeout, no retire for too many cycles");
            end
            if (expRetire.size() == 0) begin
                run = 1'b0;
            end else if (pauseLeft > 0) begin
                pauseLeft--;
                run = (pauseLeft == 0);
            end else if (pick(8) == 0) begin
                pauseLeft = 1 + pick(5);
                run = 1'b0;
            end
            if (!run) begin
                runDipped = 1'b1;
            end
        end
        // paused core must stay silent
        for (k = 0; k < 10; k++) begin
            @(negedge clk);
            cycle++;
            checkCycle();
        end
        checks[3]++;
        if (expStore.size() != 0) begin
            reportFault(3, "some expected stores never appeared");
        end

        total       = 0;
        totalChecks = 0;
        for (k = 1; k <= 6; k++) begin
            $display("test %0d %s: %0d checks, %0d errors", k, names[k], checks[k], errs[k]);
            total += errs[k];
            totalChecks += checks[k];
        end
        $display("total: %0d checks, %0d errors", totalChecks, total);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
